// ==== src/ps2_pkg.sv ====
package ps2_pkg;

  // ----------------------------------------
  // wire-level types
  // ----------------------------------------

  // one data byte of a frame
  typedef logic [7:0] scan_code_t;

  // bit position inside a frame, 0 to 10
  typedef logic [3:0] bit_index_t;

  // clk cycles since last ps2 clock fall
  typedef logic [11:0] idle_count_t;

  // ----------------------------------------
  // frame layout
  // ----------------------------------------

  // start, 8 data lsb first, odd parity, stop
  localparam int FRAME_BITS = 11;

  localparam bit_index_t BIT_START  = 4'd0;
  localparam bit_index_t BIT_PARITY = 4'd9;
  localparam bit_index_t BIT_STOP   = bit_index_t'(FRAME_BITS - 1);

  // partial frame is dropped after this many quiet cycles
  // well above one bit period of a real keyboard
  localparam idle_count_t IDLE_TIMEOUT_CYCLES = 12'd2000;

  // ----------------------------------------
  // prefix bytes of scan-code set 2
  // ----------------------------------------

  // extended key prefix
  localparam scan_code_t SC_PREFIX_EXT   = 8'hE0;
  // key release prefix
  localparam scan_code_t SC_PREFIX_BREAK = 8'hF0;

endpackage

// ==== src/key_pkg.sv ====
package key_pkg;

  // ----------------------------------------
  // key-level types
  // ----------------------------------------

  // character code
  typedef logic [7:0] ascii_t;

  // one decoded key transition
  // shift and caps already include this event
  typedef struct packed {
    ps2_pkg::scan_code_t code;
    logic                extended;
    logic                released;
    logic                shift;
    logic                caps;
  } key_event_t;

  // event plus its character
  typedef struct packed {
    key_event_t ev;
    ascii_t     ascii;
    logic       printable;
  } key_char_t;

  // prefix tracking in the decoder
  typedef enum logic [1:0] {IDLE, EXT, BREAK, EXT_BREAK} dec_state_t;

  // ----------------------------------------
  // scan codes with special meaning
  // ----------------------------------------

  localparam ps2_pkg::scan_code_t SC_LSHIFT = 8'h12;
  localparam ps2_pkg::scan_code_t SC_RSHIFT = 8'h59;
  localparam ps2_pkg::scan_code_t SC_CAPS   = 8'h58;
  localparam ps2_pkg::scan_code_t SC_SPACE  = 8'h29;
  localparam ps2_pkg::scan_code_t SC_ENTER  = 8'h5A;

  // lower case minus this gives upper case
  localparam ascii_t ASCII_CASE_OFFSET = 8'h20;

endpackage

// ==== src/ps2_frame_rx.sv ====
`timescale 1ns/1ps

module ps2_frame_rx (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                ps2_clk,
  input  logic                ps2_data,
  output logic                byte_valid,
  output ps2_pkg::scan_code_t rx_byte,
  output logic                frame_error
);

  import ps2_pkg::*;

  // ----------------------------------------
  // synchronizer and edge detect
  // ----------------------------------------

  // both lines idle high
  logic [1:0] clk_sync;
  logic [1:0] data_sync;
  // previous synchronized clock
  logic       clk_prev;
  logic       clk_fall;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clk_sync  <= '1;
      data_sync <= '1;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_prev  <= clk_sync[1];
    end
  end

  // high for one cycle per ps2 clock fall
  assign clk_fall = clk_prev & ~clk_sync[1];

  // ----------------------------------------
  // bit position and idle resync
  // ----------------------------------------

  bit_index_t  bit_idx;
  idle_count_t idle_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_idx  <= '0;
      idle_cnt <= '0;
    end else if (clk_fall) begin
      idle_cnt <= '0;
      // wrap after stop bit
      bit_idx  <= (bit_idx == BIT_STOP) ? '0 : bit_idx + 1'b1;
    end else if (idle_cnt == IDLE_TIMEOUT_CYCLES) begin
      // line quiet too long, forget partial frame
      bit_idx <= '0;
    end else begin
      idle_cnt <= idle_cnt + 1'b1;
    end
  end

  // ----------------------------------------
  // frame shifter and checks
  // ----------------------------------------

  // start, data and parity; stop is checked live
  logic [BIT_PARITY:0] frame_q;
  logic                frame_end;
  logic                start_ok;
  logic                stop_ok;
  logic                parity_ok;
  logic                frame_ok;

  always_ff @(posedge clk) begin
    if (clk_fall && bit_idx != BIT_STOP) begin
      frame_q[bit_idx] <= data_sync[1];
    end
  end

  assign frame_end = clk_fall && (bit_idx == BIT_STOP);
  assign start_ok  = ~frame_q[BIT_START];
  assign stop_ok   = data_sync[1];
  // odd parity over data and parity bit
  assign parity_ok = ^frame_q[BIT_PARITY:BIT_START+1];
  assign frame_ok  = start_ok & stop_ok & parity_ok;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      byte_valid  <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      byte_valid  <= frame_end & frame_ok;
      frame_error <= frame_end & ~frame_ok;
    end
  end

  // data byte, held until next frame
  always_ff @(posedge clk) begin
    if (frame_end) begin
      rx_byte <= frame_q[BIT_PARITY-1:BIT_START+1];
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------

  // one outcome per frame
  a_strobe_excl: assert property (
    @(posedge clk) disable iff (!arst_n) !(byte_valid && frame_error)
  );

  a_bit_range: assert property (
    @(posedge clk) disable iff (!arst_n) bit_idx <= BIT_STOP
  );

endmodule

// ==== src/scan_decoder.sv ====
`timescale 1ns/1ps

module scan_decoder (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                byte_valid,
  input  ps2_pkg::scan_code_t rx_byte,
  input  logic                frame_error,
  output logic                ev_valid,
  output key_pkg::key_event_t ev,
  output logic                caps_lock
);

  import ps2_pkg::*;
  import key_pkg::*;

  dec_state_t state;

  // shift flags, one per key
  logic lshift;
  logic rshift;
  logic lshift_nxt;
  logic rshift_nxt;
  logic caps_nxt;

  logic is_ext;
  logic is_break;
  logic in_ext;
  logic in_break;
  logic emit;

  // ----------------------------------------
  // byte classification
  // ----------------------------------------

  assign is_ext   = (rx_byte == SC_PREFIX_EXT);
  assign is_break = (rx_byte == SC_PREFIX_BREAK);
  assign in_ext   = (state == EXT) || (state == EXT_BREAK);
  assign in_break = (state == BREAK) || (state == EXT_BREAK);

  // prefixes only move the fsm
  assign emit = byte_valid & ~frame_error & ~is_ext & ~is_break;

  // ----------------------------------------
  // prefix fsm
  // ----------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else if (frame_error) begin
      // corrupted frame, drop pending prefix
      state <= IDLE;
    end else if (byte_valid) begin
      if (is_ext) begin
        state <= EXT;
      end else if (is_break) begin
        state <= in_ext ? EXT_BREAK : BREAK;
      end else begin
        state <= IDLE;
      end
    end
  end

  // ----------------------------------------
  // modifier tracking
  // ----------------------------------------

  always_comb begin
    lshift_nxt = lshift;
    rshift_nxt = rshift;
    caps_nxt   = caps_lock;
    if (emit) begin
      case (rx_byte)
        SC_LSHIFT: lshift_nxt = ~in_break;
        SC_RSHIFT: rshift_nxt = ~in_break;
        // toggle on make only
        SC_CAPS: caps_nxt = in_break ? caps_lock : ~caps_lock;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lshift    <= 1'b0;
      rshift    <= 1'b0;
      caps_lock <= 1'b0;
      ev_valid  <= 1'b0;
    end else begin
      lshift    <= lshift_nxt;
      rshift    <= rshift_nxt;
      caps_lock <= caps_nxt;
      ev_valid  <= emit;
    end
  end

  // event payload, modifiers after this key
  always_ff @(posedge clk) begin
    if (emit) begin
      ev <= '{code:     rx_byte,
              extended: in_ext,
              released: in_break,
              shift:    lshift_nxt | rshift_nxt,
              caps:     caps_nxt};
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------

  a_ev_after_byte: assert property (
    @(posedge clk) disable iff (!arst_n) ev_valid |-> $past(byte_valid)
  );

  a_no_prefix_ev: assert property (
    @(posedge clk) disable iff (!arst_n)
      ev_valid |-> (ev.code != SC_PREFIX_EXT) && (ev.code != SC_PREFIX_BREAK)
  );

endmodule

// ==== src/ascii_mapper.sv ====
`timescale 1ns/1ps

module ascii_mapper (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                ev_valid,
  input  key_pkg::key_event_t ev,
  output logic                key_valid,
  output key_pkg::key_char_t  key
);

  import key_pkg::*;

  // unshifted character, zero when unmapped
  ascii_t plain_char;
  // digit row symbol, zero elsewhere
  ascii_t digit_sym;
  ascii_t char_sel;
  logic   is_letter;
  logic   printable;

  // ----------------------------------------
  // set 2 lookup
  // ----------------------------------------

  always_comb begin
    plain_char = '0;
    case (ev.code)
      8'h1C: plain_char = "a";
      8'h32: plain_char = "b";
      8'h21: plain_char = "c";
      8'h23: plain_char = "d";
      8'h24: plain_char = "e";
      8'h2B: plain_char = "f";
      8'h34: plain_char = "g";
      8'h33: plain_char = "h";
      8'h43: plain_char = "i";
      8'h3B: plain_char = "j";
      8'h42: plain_char = "k";
      8'h4B: plain_char = "l";
      8'h3A: plain_char = "m";
      8'h31: plain_char = "n";
      8'h44: plain_char = "o";
      8'h4D: plain_char = "p";
      8'h15: plain_char = "q";
      8'h2D: plain_char = "r";
      8'h1B: plain_char = "s";
      8'h2C: plain_char = "t";
      8'h3C: plain_char = "u";
      8'h2A: plain_char = "v";
      8'h1D: plain_char = "w";
      8'h22: plain_char = "x";
      8'h35: plain_char = "y";
      8'h1A: plain_char = "z";
      8'h16: plain_char = "1";
      8'h1E: plain_char = "2";
      8'h26: plain_char = "3";
      8'h25: plain_char = "4";
      8'h2E: plain_char = "5";
      8'h36: plain_char = "6";
      8'h3D: plain_char = "7";
      8'h3E: plain_char = "8";
      8'h46: plain_char = "9";
      8'h45: plain_char = "0";
      SC_SPACE: plain_char = 8'h20;
      SC_ENTER: plain_char = 8'h0D;
      default: ;
    endcase
  end

  // us layout symbols above the digits
  always_comb begin
    digit_sym = '0;
    case (ev.code)
      8'h16: digit_sym = "!";
      8'h1E: digit_sym = "@";
      8'h26: digit_sym = "#";
      8'h25: digit_sym = "$";
      8'h2E: digit_sym = "%";
      8'h36: digit_sym = "^";
      8'h3D: digit_sym = "&";
      8'h3E: digit_sym = "*";
      8'h46: digit_sym = "(";
      8'h45: digit_sym = ")";
      default: ;
    endcase
  end

  assign is_letter = (plain_char >= "a") && (plain_char <= "z");

  // caps only flips letters, shift flips letters and digits
  always_comb begin
    if (is_letter && (ev.shift ^ ev.caps)) begin
      char_sel = plain_char - ASCII_CASE_OFFSET;
    end else if (digit_sym != '0 && ev.shift) begin
      char_sel = digit_sym;
    end else begin
      char_sel = plain_char;
    end
  end

  // make of a plain key only
  assign printable = (plain_char != '0) & ~ev.released & ~ev.extended;

  // ----------------------------------------
  // output register
  // ----------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      key_valid <= 1'b0;
    end else begin
      key_valid <= ev_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ev_valid) begin
      key <= '{ev: ev, ascii: printable ? char_sel : '0, printable: printable};
    end
  end

  a_printable_ascii: assert property (
    @(posedge clk) disable iff (!arst_n)
      key_valid && key.printable |-> key.ascii != '0
  );

endmodule

// ==== src/ps2_keyboard.sv ====
`timescale 1ns/1ps

module ps2_keyboard (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               ps2_clk,
  input  logic               ps2_data,
  output logic               key_valid,
  output key_pkg::key_char_t key,
  output logic               frame_error,
  output logic               caps_lock
);

  import ps2_pkg::*;
  import key_pkg::*;

  // receiver to decoder
  logic       byte_valid;
  scan_code_t rx_byte;

  // decoder to mapper
  logic       ev_valid;
  key_event_t ev;

  // ----------------------------------------
  // frame capture
  // ----------------------------------------

  ps2_frame_rx u_frame_rx (
    .clk         (clk),
    .arst_n      (arst_n),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .byte_valid  (byte_valid),
    .rx_byte     (rx_byte),
    .frame_error (frame_error)
  );

  // prefixes and modifiers
  scan_decoder u_decoder (
    .clk         (clk),
    .arst_n      (arst_n),
    .byte_valid  (byte_valid),
    .rx_byte     (rx_byte),
    .frame_error (frame_error),
    .ev_valid    (ev_valid),
    .ev          (ev),
    .caps_lock   (caps_lock)
  );

  // character lookup
  ascii_mapper u_mapper (
    .clk       (clk),
    .arst_n    (arst_n),
    .ev_valid  (ev_valid),
    .ev        (ev),
    .key_valid (key_valid),
    .key       (key)
  );

endmodule

// ==== test/tb_ps2_keyboard.sv ====
`timescale 1ns/1ps

module tb_ps2_keyboard;

  import ps2_pkg::*;
  import key_pkg::*;

  // ----------------------------------------
  // timing and key tables
  // ----------------------------------------

  localparam int CLK_PERIOD = 8;
  // device clock half period in clk cycles
  localparam int HALF_BIT   = 20;
  // quiet time after each frame, longer than the idle timeout
  localparam int GAP_CYCLES = int'(IDLE_TIMEOUT_CYCLES) + 200;
  // last falling edge to key_valid
  localparam int KEY_LATENCY_CYCLES = 5;
  // all frames of the six tests
  localparam int PLANNED_FRAMES = 115;
  // twice the expected run length
  localparam longint WATCHDOG_NS = longint'(PLANNED_FRAMES) *
    (2 * FRAME_BITS * HALF_BIT + GAP_CYCLES) * CLK_PERIOD * 2;

  // letters a to z, digits 1 to 0, then space and enter
  localparam int NUM_KEYS = 38;
  localparam scan_code_t KEY_CODES [0:NUM_KEYS-1] = '{
    8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
    8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
    8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A, 8'h16, 8'h1E, 8'h26, 8'h25,
    8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46, 8'h45, 8'h29, 8'h5A
  };
  localparam string KEY_TEXT   = "abcdefghijklmnopqrstuvwxyz1234567890";
  localparam string DIGIT_SYMS = "!@#$%^&*()";
  // arrows and keypad enter, all behind E0
  localparam scan_code_t EXT_CODES [0:2] = '{8'h75, 8'h6B, 8'h5A};

  logic       clk;
  logic       arst_n;
  logic       ps2_clk;
  logic       ps2_data;
  logic       key_valid;
  key_char_t  key;
  logic       frame_error;
  logic       caps_lock;

  // model of the modifier state
  logic        ref_lshift;
  logic        ref_rshift;
  logic        ref_caps;
  logic [31:0] rng_state;
  key_char_t   exp_q[$];
  key_char_t   exp_key;
  int          errors_expected;
  int          errors_seen;
  time         last_fall_time;

  ps2_keyboard DUT (
    .clk         (clk),
    .arst_n      (arst_n),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .key_valid   (key_valid),
    .key         (key),
    .frame_error (frame_error),
    .caps_lock   (caps_lock)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ----------------------------------------
  // reporting
  // ----------------------------------------

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic compare_key_char(input string name, input key_char_t got,
                                  input key_char_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_with_failure("key record differs from the reference");
    end
  endtask

  task automatic compare_logic(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_with_failure("status bit differs from the reference");
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      stop_with_failure("count differs from the expected value");
    end
  endtask

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  // 32-bit lcg, numerical recipes constants
  function automatic int rand_below(input int n);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return int'(rng_state[30:16]) % n;
  endfunction

  function automatic scan_code_t random_key();
    return KEY_CODES[rand_below(NUM_KEYS)];
  endfunction

  // table position, -1 for unmapped codes
  function automatic int key_slot(input scan_code_t code);
    for (int i = 0; i < NUM_KEYS; i++) begin
      if (KEY_CODES[i] == code) return i;
    end
    return -1;
  endfunction

  // expected record, modifiers updated first
  function automatic key_char_t ref_key(input scan_code_t code, input logic ext,
                                        input logic rel);
    key_char_t r;
    int        slot;
    slot = key_slot(code);
    if (code == SC_LSHIFT) ref_lshift = ~rel;
    if (code == SC_RSHIFT) ref_rshift = ~rel;
    // caps toggles on make only
    if (code == SC_CAPS && !rel) ref_caps = ~ref_caps;
    r = '0;
    r.ev.code     = code;
    r.ev.extended = ext;
    r.ev.released = rel;
    r.ev.shift    = ref_lshift | ref_rshift;
    r.ev.caps     = ref_caps;
    if (slot >= 0 && !rel && !ext) begin
      r.printable = 1'b1;
      if (slot < 26) begin
        // upper case is 20 below lower case
        r.ascii = (r.ev.shift ^ ref_caps) ? KEY_TEXT[slot] - 8'h20 : KEY_TEXT[slot];
      end else if (slot < 36) begin
        r.ascii = r.ev.shift ? DIGIT_SYMS[slot - 26] : KEY_TEXT[slot];
      end else begin
        r.ascii = (slot == 36) ? 8'h20 : 8'h0D;
      end
    end
    return r;
  endfunction

  // ----------------------------------------
  // device model
  // ----------------------------------------

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // data set while clock high, sampled on the fall
  task automatic drive_frame(input scan_code_t b, input logic bad_parity,
                             input logic bad_stop, input int n_bits);
    logic [10:0] bits;
    bits = {~bad_stop, (~^b) ^ bad_parity, b, 1'b0};
    for (int i = 0; i < n_bits; i++) begin
      @(posedge clk);
      ps2_data <= bits[i];
      wait_cycles(HALF_BIT);
      ps2_clk <= 1'b0;
      last_fall_time = $time;
      wait_cycles(HALF_BIT);
      ps2_clk <= 1'b1;
    end
    ps2_data <= 1'b1;
    wait_cycles(GAP_CYCLES);
  endtask

  task automatic send_byte(input scan_code_t b);
    drive_frame(b, 1'b0, 1'b0, FRAME_BITS);
  endtask

  // expectation queued before the last frame goes out
  task automatic press_key(input scan_code_t code, input logic ext);
    if (ext) send_byte(SC_PREFIX_EXT);
    exp_q.push_back(ref_key(code, ext, 1'b0));
    send_byte(code);
  endtask

  task automatic release_key(input scan_code_t code, input logic ext);
    if (ext) send_byte(SC_PREFIX_EXT);
    send_byte(SC_PREFIX_BREAK);
    exp_q.push_back(ref_key(code, ext, 1'b1));
    send_byte(code);
  endtask

  task automatic tap_key(input scan_code_t code);
    press_key(code, 1'b0);
    release_key(code, 1'b0);
  endtask

  task automatic end_test(input string name);
    compare_count({name, " keys left"}, exp_q.size(), 0);
    compare_count({name, " frame errors"}, errors_seen, errors_expected);
    compare_logic({name, " caps_lock"}, caps_lock, ref_caps);
    $display("%s done", name);
  endtask

  // ----------------------------------------
  // compare process and watchdog
  // ----------------------------------------

  // key_valid is seen one edge after it rises
  always @(posedge clk) begin
    if (key_valid) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("key_valid pulsed with no key expected");
      end else begin
        exp_key = exp_q.pop_front();
        compare_key_char("key", key, exp_key);
        compare_count("key latency", int'(($time - last_fall_time) / CLK_PERIOD),
                      KEY_LATENCY_CYCLES + 1);
      end
    end
    if (frame_error) begin
      errors_seen++;
      if (errors_seen > errors_expected) stop_with_failure("unexpected frame_error");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    stop_with_failure("watchdog expired before all tests finished");
  end

  initial begin
    arst_n          = 1'b0;
    ps2_clk         = 1'b1;
    ps2_data        = 1'b1;
    ref_lshift      = 1'b0;
    ref_rshift      = 1'b0;
    ref_caps        = 1'b0;
    rng_state       = 32'hf6bc05dd;
    errors_expected = 0;
    errors_seen     = 0;
    last_fall_time  = 0;
    wait_cycles(3);
    arst_n <= 1'b1;
    wait_cycles(5);

    // plain make and break
    repeat (8) tap_key(random_key());
    end_test("make and break");

    // left then right shift held
    for (int s = 0; s < 2; s++) begin
      press_key(s ? SC_RSHIFT : SC_LSHIFT, 1'b0);
      repeat (3) tap_key(random_key());
      // digit 2 gives its symbol
      tap_key(8'h1E);
      release_key(s ? SC_RSHIFT : SC_LSHIFT, 1'b0);
      tap_key(random_key());
    end
    end_test("shift");

    // caps on, then caps with shift, then caps off
    tap_key(SC_CAPS);
    end_test("caps on");
    repeat (3) tap_key(random_key());
    // digit 0 stays a digit under caps
    tap_key(8'h45);
    press_key(SC_LSHIFT, 1'b0);
    repeat (2) tap_key(random_key());
    // letter a back to lower case
    tap_key(8'h1C);
    release_key(SC_LSHIFT, 1'b0);
    tap_key(SC_CAPS);
    end_test("caps off");

    // extended make and break
    foreach (EXT_CODES[i]) begin
      press_key(EXT_CODES[i], 1'b1);
      release_key(EXT_CODES[i], 1'b1);
    end
    end_test("extended");

    // bad parity, then bad stop after a pending F0
    errors_expected++;
    drive_frame(8'h1C, 1'b1, 1'b0, FRAME_BITS);
    send_byte(SC_PREFIX_BREAK);
    errors_expected++;
    drive_frame(8'h1B, 1'b0, 1'b1, FRAME_BITS);
    tap_key(8'h1C);
    end_test("frame errors");

    // 5 bits then silence
    drive_frame(8'h24, 1'b0, 1'b0, 5);
    tap_key(random_key());
    end_test("idle resync");

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== list.f ====
src/ps2_pkg.sv
src/key_pkg.sv
src/ps2_frame_rx.sv
src/scan_decoder.sv
src/ascii_mapper.sv
src/ps2_keyboard.sv
test/tb_ps2_keyboard.sv

// ==== Makefile ====
# Verilator flow for the PS/2 keyboard receiver

VERILATOR ?= verilator
TOP       ?= tb_ps2_keyboard
RTL_TOP   ?= ps2_keyboard
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
RTL_SRCS  ?= src/ps2_pkg.sv src/key_pkg.sv src/ps2_frame_rx.sv \
             src/scan_decoder.sv src/ascii_mapper.sv src/ps2_keyboard.sv

.PHONY: all lint sim clean

all: sim

# design alone, then design with testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status of the simulation binary is the result
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
